// File: vlog.f
+incdir+include
hdl/l2_pkg.sv
hdl/l2_controller.sv
hdl/cache_way.sv
hdl/way_merge.sv
hdl/l2_cache_top.sv
bench/clock_gen.sv
bench/l2_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the L2 cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module l2_cache_tb \
  -Mdir obj_dir -o l2_cache_sim

output=$(./obj_dir/l2_cache_sim)
printf '%s\n' "$output"

# Result is decided by the final message
if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
exit 1

// File: bench/l2_cache_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache testbench
// Table driven requests, memory
// responder and result checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "l2_settings.svh"

module l2_cache_tb;

  // One row of the stimulus table
  typedef struct packed {
    l2_pkg::req_kind_e kind;
    l2_pkg::addr_t     addr;
    l2_pkg::word_t     wdata;
    l2_pkg::word_t     exp_data;
    logic              exp_wb;
    l2_pkg::addr_t     exp_wb_addr;
    logic              exp_mem_req;
    logic              busy_strobe;
  } entry_t;

  logic             stb;
  logic             stb_n;
  logic             req_strobe;
  l2_pkg::cpu_req_t req;
  logic             mem_beat;
  l2_pkg::beat_t    mem_data;
  logic             busy;
  logic             done;
  l2_pkg::word_t    rdata;
  logic             mem_req;
  l2_pkg::addr_t    mem_addr;
  logic             write_back;
  l2_pkg::addr_t    wb_addr;

  entry_t tests[$];
  int     err_cnt = 0;
  int     pass_cnt = 0;
  int     fail_cnt = 0;
  int     cycle_cnt = 0;
  int     cycle_limit = 0;
  int     beat_cycle = 0;

  clock_gen clock_gen_inst (.stb(stb), .stb_n(stb_n));

  l2_cache_top l2_cache_top_inst (
    .stb(stb), .stb_n(stb_n), .req_strobe(req_strobe), .req(req),
    .mem_beat(mem_beat), .mem_data(mem_data), .busy(busy), .done(done),
    .rdata(rdata), .mem_req(mem_req), .mem_addr(mem_addr),
    .write_back(write_back), .wb_addr(wb_addr)
  );

  // Memory contents, byte address XOR a fixed pattern
  function automatic l2_pkg::word_t mem_word(input l2_pkg::addr_t a);
    return a ^ 32'hA5A5_0000;
  endfunction

  // Beat b of a line, lower word first
  function automatic l2_pkg::beat_t fill_beat(input l2_pkg::addr_t line, input int b);
    return {mem_word(line + l2_pkg::addr_t'(b * 8 + 4)), mem_word(line + l2_pkg::addr_t'(b * 8))};
  endfunction

  function automatic l2_pkg::addr_t line_of(input l2_pkg::addr_t a);
    return {a[31:`L2_INDEX_LSB], {`L2_INDEX_LSB{1'b0}}};
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR: %s", msg);
    err_cnt++;
  endtask

  task automatic check_word(input string name, input l2_pkg::word_t got, input l2_pkg::word_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_addr(input string name, input l2_pkg::addr_t got, input l2_pkg::addr_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic add_entry(input l2_pkg::req_kind_e kind, input l2_pkg::addr_t addr,
                           input l2_pkg::word_t wdata, input l2_pkg::word_t exp_data,
                           input logic exp_wb, input l2_pkg::addr_t exp_wb_addr,
                           input logic exp_mem_req, input logic busy_strobe);
    entry_t e;
    e = {kind, addr, wdata, exp_data, exp_wb, exp_wb_addr, exp_mem_req, busy_strobe};
    tests.push_back(e);
  endtask

  // Strobe one request, watch outputs until done plus two quiet cycles
  task automatic run_entry(input int num, input entry_t t);
    l2_pkg::cpu_req_t  extra;
    l2_pkg::req_kind_e kind_q;
    l2_pkg::word_t     got_data;
    l2_pkg::addr_t     got_mem_addr;
    l2_pkg::addr_t     got_wb_addr;
    int                errs_before;
    int                done_cnt;
    int                mem_cnt;
    int                wb_cnt;
    int                samples;
    int                done_at;
    int                done_gap;
    int                post;
    errs_before = err_cnt;
    kind_q = t.kind;
    done_cnt = 0;
    mem_cnt = 0;
    wb_cnt = 0;
    samples = 0;
    done_at = 0;
    done_gap = 0;
    post = 0;
    got_data = '0;
    got_mem_addr = '0;
    got_wb_addr = '0;
    // Store that must be dropped while busy
    extra = {l2_pkg::cpu_write, 32'h0000_1004, 32'h0BAD_F00D};
    @(negedge stb);
    req = {t.kind, t.addr, t.wdata};
    req_strobe = 1'b1;
    @(negedge stb);
    req_strobe = 1'b0;
    if (t.busy_strobe)
    begin
      check_flag("busy", busy, 1'b1);
      req = extra;
      req_strobe = 1'b1;
    end
    @(negedge stb);
    req_strobe = 1'b0;
    while (post < 3)
    begin
      if (mem_req)
      begin
        mem_cnt++;
        got_mem_addr = mem_addr;
      end
      if (write_back)
      begin
        wb_cnt++;
        got_wb_addr = wb_addr;
      end
      if (done)
      begin
        done_cnt++;
        if (done_cnt == 1)
        begin
          got_data = rdata;
          done_at = samples;
          done_gap = cycle_cnt - beat_cycle;
        end
      end
      if (done_cnt > 0)
        post++;
      samples++;
      @(negedge stb);
    end
    check_flag("mem_req", mem_cnt > 0, t.exp_mem_req);
    if (mem_cnt > 0)
      check_addr("mem_addr", got_mem_addr, line_of(t.addr));
    if (mem_cnt > 1)
      report_error($sformatf("%0d memory requests seen where at most one was due", mem_cnt));
    check_flag("write_back", wb_cnt > 0, t.exp_wb);
    if (t.exp_wb && wb_cnt > 0)
      check_addr("wb_addr", got_wb_addr, t.exp_wb_addr);
    if (wb_cnt > 1)
      report_error($sformatf("%0d write-back pulses seen for one request", wb_cnt));
    if (done_cnt != 1)
      report_error($sformatf("expected exactly one done pulse but saw %0d", done_cnt));
    // Hits and snoops finish two edges after the strobe
    if (!t.exp_mem_req && done_at != 0)
      report_error($sformatf("done arrived %0d cycles later than expected", done_at));
    // Read miss ends one edge after the last beat, a store needs one more
    if (t.exp_mem_req && mem_cnt > 0 && done_cnt == 1 &&
        done_gap != ((t.kind == l2_pkg::cpu_write) ? 2 : 1))
      report_error($sformatf("done came %0d cycles after the last memory beat", done_gap));
    if (t.kind == l2_pkg::cpu_read)
      check_word("rdata", got_data, t.exp_data);
    if (err_cnt == errs_before)
      pass_cnt++;
    else
      fail_cnt++;
    $display("test %0d %s at %h: %s", num, kind_q.name(), t.addr,
             (err_cnt == errs_before) ? "ok" : "FAILED");
  endtask

  task automatic build_table();
    // Read miss into empty set 0, then repeat hit
    add_entry(l2_pkg::cpu_read, 32'h0000_1008, '0, mem_word(32'h0000_1008), 1'b0, '0, 1'b1, 1'b0);
    add_entry(l2_pkg::cpu_read, 32'h0000_100C, '0, mem_word(32'h0000_100C), 1'b0, '0, 1'b0, 1'b0);
    // Write hit makes the line Modified
    add_entry(l2_pkg::cpu_write, 32'h0000_1004, 32'hDEAD_BEEF, '0, 1'b0, '0, 1'b0, 1'b0);
    add_entry(l2_pkg::cpu_read, 32'h0000_1004, '0, 32'hDEAD_BEEF, 1'b0, '0, 1'b0, 1'b0);
    // Set 1 filled by four tags, the write miss lands in way 1
    add_entry(l2_pkg::cpu_read, 32'h0000_2010, '0, mem_word(32'h0000_2010), 1'b0, '0, 1'b1, 1'b0);
    add_entry(l2_pkg::cpu_write, 32'h0000_3014, 32'h1111_1111, '0, 1'b0, '0, 1'b1, 1'b0);
    add_entry(l2_pkg::cpu_read, 32'h0000_4018, '0, mem_word(32'h0000_4018), 1'b0, '0, 1'b1, 1'b0);
    add_entry(l2_pkg::cpu_read, 32'h0000_501C, '0, mem_word(32'h0000_501C), 1'b0, '0, 1'b1, 1'b0);
    // Hit on way 0 leaves the Modified line oldest
    add_entry(l2_pkg::cpu_read, 32'h0000_2010, '0, mem_word(32'h0000_2010), 1'b0, '0, 1'b0, 1'b0);
    // Fifth tag evicts the Modified LRU line
    add_entry(l2_pkg::cpu_read, 32'h0000_6010, '0, mem_word(32'h0000_6010),
              1'b1, 32'h0000_3010, 1'b1, 1'b0);
    // Evicted tag misses again, memory copy returns
    add_entry(l2_pkg::cpu_read, 32'h0000_3014, '0, mem_word(32'h0000_3014), 1'b0, '0, 1'b1, 1'b0);
    // Snooped reads of a Modified line
    add_entry(l2_pkg::snoop_read, 32'h0000_1000, '0, '0, 1'b1, 32'h0000_1000, 1'b0, 1'b0);
    add_entry(l2_pkg::snoop_read, 32'h0000_1000, '0, '0, 1'b0, '0, 1'b0, 1'b0);
    add_entry(l2_pkg::cpu_read, 32'h0000_1004, '0, 32'hDEAD_BEEF, 1'b0, '0, 1'b0, 1'b0);
    // Snooped write invalidates, next read misses
    add_entry(l2_pkg::snoop_write, 32'h0000_5010, '0, '0, 1'b0, '0, 1'b0, 1'b0);
    add_entry(l2_pkg::cpu_read, 32'h0000_5018, '0, mem_word(32'h0000_5018), 1'b0, '0, 1'b1, 1'b0);
    // Snoops to absent lines
    add_entry(l2_pkg::snoop_read, 32'h0000_7020, '0, '0, 1'b0, '0, 1'b0, 1'b0);
    add_entry(l2_pkg::snoop_write, 32'h0000_9010, '0, '0, 1'b0, '0, 1'b0, 1'b0);
    // Way 0 of set 1 survives the absent snoop
    add_entry(l2_pkg::cpu_read, 32'h0000_2010, '0, mem_word(32'h0000_2010), 1'b0, '0, 1'b0, 1'b0);
    // Second strobe while busy is dropped
    add_entry(l2_pkg::cpu_read, 32'h0000_A024, '0, mem_word(32'h0000_A024), 1'b0, '0, 1'b1, 1'b1);
    add_entry(l2_pkg::cpu_read, 32'h0000_1004, '0, 32'hDEAD_BEEF, 1'b0, '0, 1'b0, 1'b0);
  endtask

  // Memory side, two beats per request after random gaps
  initial
  begin : mem_responder
    l2_pkg::addr_t line;
    int            gap;
    mem_beat = 1'b0;
    mem_data = '0;
    void'($urandom(8));
    forever
    begin
      @(negedge stb);
      if (mem_req)
      begin
        line = mem_addr;
        for (int b = 0; b < `L2_BEATS; b++)
        begin
          gap = int'($urandom_range(3, 0));
          repeat (gap)
          begin
            mem_beat = 1'b0;
            @(negedge stb);
          end
          mem_beat = 1'b1;
          mem_data = fill_beat(line, b);
          @(negedge stb);
        end
        mem_beat = 1'b0;
      end
    end
  end

  // Edge count just before the latest beat the DUT took
  always @(posedge stb)
  begin
    if (mem_beat)
      beat_cycle <= cycle_cnt;
  end

  // Run limit
  always @(posedge stb)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
    begin
      $display("Timeout: %0d cycles passed and the tests had not finished", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial
  begin
    req_strobe = 1'b0;
    req = '0;
    build_table();
    cycle_limit = 40 * tests.size() + 4;
    @(posedge stb_n);
    // Quiet outputs out of reset
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
    check_flag("mem_req", mem_req, 1'b0);
    check_flag("write_back", write_back, 1'b0);
    for (int i = 0; i < tests.size(); i++)
      run_entry(i, tests[i]);
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests.size(), pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: bench/clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
// Period 20, reset low 4 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module clock_gen (
  output logic stb,
  output logic stb_n
);

  localparam int half_period = 10;
  localparam int reset_cycles = 4;

  initial
  begin
    stb = 1'b0;
    forever #half_period stb = ~stb;
  end

  // Release away from the rising edge
  initial
  begin
    stb_n = 1'b0;
    repeat (reset_cycles) @(posedge stb);
    @(negedge stb);
    stb_n = 1'b1;
  end

endmodule

// File: hdl/l2_cache_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache top level
// Controller, four ways, merge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "l2_settings.svh"

module l2_cache_top (
  input  logic             stb,
  input  logic             stb_n,
  input  logic             req_strobe,
  input  l2_pkg::cpu_req_t req,
  input  logic             mem_beat,
  input  l2_pkg::beat_t    mem_data,
  output logic             busy,
  output logic             done,
  output l2_pkg::word_t    rdata,
  output logic             mem_req,
  output l2_pkg::addr_t    mem_addr,
  output logic             write_back,
  output l2_pkg::addr_t    wb_addr
);

  l2_pkg::way_cmd_t      way_cmd;
  l2_pkg::way_status_t   way_status [`L2_WAYS];
  l2_pkg::merge_result_t merged;

  // Sequencer and command source
  l2_controller l2_controller_inst (
    .stb        (stb),
    .stb_n      (stb_n),
    .req_strobe (req_strobe),
    .req        (req),
    .mem_beat   (mem_beat),
    .mem_data   (mem_data),
    .merged     (merged),
    .way_cmd    (way_cmd),
    .busy       (busy),
    .done       (done),
    .rdata      (rdata),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .write_back (write_back),
    .wb_addr    (wb_addr)
  );

  // One instance per way, loop index sets the starting age
  for (genvar g = 0; g < `L2_WAYS; g++)
  begin : g_way
    cache_way #(
      .way_num (g)
    ) cache_way_inst (
      .stb     (stb),
      .stb_n   (stb_n),
      .way_cmd (way_cmd),
      .way_sel (way_cmd.target[g]),
      .status  (way_status[g])
    );
  end

  way_merge way_merge_inst (
    .status (way_status),
    .merged (merged)
  );

endmodule

// File: hdl/way_merge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Way status merge
// Hit encode, read word mux and
// victim selection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "l2_settings.svh"

module way_merge (
  input  l2_pkg::way_status_t   status [`L2_WAYS],
  output l2_pkg::merge_result_t merged
);

  l2_pkg::way_id_t hit_way;
  l2_pkg::way_id_t lru_way;
  l2_pkg::way_id_t victim_way;
  logic            any_hit;
  logic            inv_found;

  always_comb
  begin
    any_hit    = 1'b0;
    hit_way    = '0;
    lru_way    = '0;
    victim_way = '0;
    inv_found  = 1'b0;

    for (int w = 0; w < `L2_WAYS; w++)
    begin
      // At most one way holds a given tag
      if (status[w].hit)
      begin
        any_hit = 1'b1;
        hit_way = l2_pkg::way_id_t'(w);
      end
      // Oldest way in the set
      if (status[w].age == '0)
        lru_way = l2_pkg::way_id_t'(w);
      // Lowest numbered empty way wins
      if (!inv_found && (status[w].state == l2_pkg::invalid))
      begin
        inv_found  = 1'b1;
        victim_way = l2_pkg::way_id_t'(w);
      end
    end

    // Full set falls back to LRU
    if (!inv_found)
      victim_way = lru_way;

    merged.any_hit      = any_hit;
    merged.hit_way      = hit_way;
    merged.hit_state    = status[hit_way].state;
    merged.hit_age      = status[hit_way].age;
    merged.rword        = status[hit_way].rword;
    // Victim details for the write-back address and LRU touch
    merged.victim_way   = victim_way;
    merged.victim_state = status[victim_way].state;
    merged.victim_tag   = status[victim_way].tag;
    merged.victim_age   = status[victim_way].age;
  end

endmodule

// File: hdl/cache_way.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache way
// Tag, MESI, LRU age and data
// per set, plus tag compare
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "l2_settings.svh"

module cache_way #(
  parameter int way_num = 0
) (
  input  logic                stb,
  input  logic                stb_n,
  input  l2_pkg::way_cmd_t    way_cmd,
  input  logic                way_sel,
  output l2_pkg::way_status_t status
);

  localparam int words_per_beat = `L2_LINE_WORDS / `L2_BEATS;
  localparam int word_bits      = $bits(l2_pkg::word_t);

  // Per set storage
  l2_pkg::tag_t  tag_mem   [`L2_SETS];
  l2_pkg::mesi_e state_mem [`L2_SETS];
  l2_pkg::age_t  age_mem   [`L2_SETS];
  l2_pkg::word_t data_mem  [`L2_SETS][`L2_LINE_WORDS];

  logic              touch_self;
  l2_pkg::age_t      cur_age;
  l2_pkg::word_sel_t fill_base;

  // This way is the one being made most recent
  assign touch_self = (way_cmd.touch_way == l2_pkg::way_id_t'(way_num));
  assign cur_age    = age_mem[way_cmd.index];
  // First word written by this beat
  assign fill_base  = l2_pkg::word_sel_t'(way_cmd.beat_num) << $clog2(words_per_beat);

  // Lookup for the command index
  always_comb
  begin
    status.state = state_mem[way_cmd.index];
    status.age   = age_mem[way_cmd.index];
    status.tag   = tag_mem[way_cmd.index];
    status.rword = data_mem[way_cmd.index][way_cmd.word];
    // Invalid lines never hit
    status.hit   = (state_mem[way_cmd.index] != l2_pkg::invalid) &&
                   (tag_mem[way_cmd.index] == way_cmd.tag);
  end

  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
    begin
      for (int s = 0; s < `L2_SETS; s++)
      begin
        tag_mem[s]   <= '0;
        state_mem[s] <= l2_pkg::invalid;
        // Way number seeds the LRU order
        age_mem[s]   <= l2_pkg::age_t'(way_num);
        for (int w = 0; w < `L2_LINE_WORDS; w++)
          data_mem[s][w] <= '0;
      end
    end
    else
    begin
      // Burst fill, several words per beat
      if (way_sel && way_cmd.fill_beat)
      begin
        for (int i = 0; i < words_per_beat; i++)
          data_mem[way_cmd.index][fill_base + l2_pkg::word_sel_t'(i)] <=
            way_cmd.wdata[i*word_bits +: word_bits];
        // Tag lands with the first beat
        if (way_cmd.beat_num == '0)
          tag_mem[way_cmd.index] <= way_cmd.tag;
      end

      // Processor store
      if (way_sel && way_cmd.write_word)
        data_mem[way_cmd.index][way_cmd.word] <= way_cmd.wdata[word_bits-1:0];

      // MESI transition
      if (way_sel && way_cmd.set_state)
        state_mem[way_cmd.index] <= way_cmd.new_state;

      // LRU update seen by every way of the set
      if (way_cmd.touch)
      begin
        if (touch_self)
          age_mem[way_cmd.index] <= '1;
        else if (cur_age > way_cmd.touch_age)
          age_mem[way_cmd.index] <= cur_age - 1'b1;
      end
    end
  end

endmodule

// File: hdl/l2_controller.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache controller FSM
// Lookup, line fill, word write,
// snoop handling and LRU touch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "l2_settings.svh"

module l2_controller (
  input  logic                  stb,
  input  logic                  stb_n,
  input  logic                  req_strobe,
  input  l2_pkg::cpu_req_t      req,
  input  logic                  mem_beat,
  input  l2_pkg::beat_t         mem_data,
  input  l2_pkg::merge_result_t merged,
  output l2_pkg::way_cmd_t      way_cmd,
  output logic                  busy,
  output logic                  done,
  output l2_pkg::word_t         rdata,
  output logic                  mem_req,
  output l2_pkg::addr_t         mem_addr,
  output logic                  write_back,
  output l2_pkg::addr_t         wb_addr
);

  localparam int words_per_beat = `L2_LINE_WORDS / `L2_BEATS;
  localparam int lane_bits      = $clog2(words_per_beat);
  localparam int beat_bits      = $clog2(`L2_BEATS);
  localparam int word_bits      = $bits(l2_pkg::word_t);
  localparam int sel_bits       = $bits(l2_pkg::word_sel_t);

  l2_pkg::ctrl_state_e   state;
  l2_pkg::cpu_req_t      req_q;
  l2_pkg::way_id_t       victim_q;
  l2_pkg::age_t          victim_age_q;
  logic [beat_bits-1:0]  beat_cnt;
  logic                  is_snoop;
  logic                  is_write;
  l2_pkg::tag_t          req_tag;
  l2_pkg::index_t        req_index;
  l2_pkg::word_sel_t     req_word;
  l2_pkg::addr_t         req_line;
  l2_pkg::way_vec_t      hit_sel;
  l2_pkg::way_vec_t      victim_sel;

  // Status outputs decode the state register
  assign busy = (state != l2_pkg::idle);
  assign done = (state == l2_pkg::respond);

  assign is_snoop  = (req_q.kind == l2_pkg::snoop_read) || (req_q.kind == l2_pkg::snoop_write);
  assign is_write  = (req_q.kind == l2_pkg::cpu_write);
  assign req_tag   = req_q.addr[31:`L2_TAG_LSB];
  assign req_index = req_q.addr[`L2_TAG_LSB-1:`L2_INDEX_LSB];
  assign req_word  = req_q.addr[`L2_INDEX_LSB-1:`L2_WORD_LSB];
  // Line aligned request address
  assign req_line  = {req_tag, req_index, {`L2_INDEX_LSB{1'b0}}};

  // One hot way selects
  assign hit_sel    = l2_pkg::way_vec_t'(1) << merged.hit_way;
  assign victim_sel = l2_pkg::way_vec_t'(1) << victim_q;

  always_ff @(posedge stb or negedge stb_n)
  begin
    if (!stb_n)
    begin
      state        <= l2_pkg::idle;
      req_q        <= '0;
      way_cmd      <= '0;
      victim_q     <= '0;
      victim_age_q <= '0;
      beat_cnt     <= '0;
      rdata        <= '0;
      mem_req      <= 1'b0;
      mem_addr     <= '0;
      write_back   <= 1'b0;
      wb_addr      <= '0;
    end
    else
    begin
      // Pulses last one cycle
      mem_req            <= 1'b0;
      write_back         <= 1'b0;
      way_cmd.fill_beat  <= 1'b0;
      way_cmd.write_word <= 1'b0;
      way_cmd.set_state  <= 1'b0;
      way_cmd.touch      <= 1'b0;

      case (state)
        l2_pkg::idle:
        begin
          // Strobes while busy never reach here
          if (req_strobe)
          begin
            req_q         <= req;
            way_cmd.index <= req.addr[`L2_TAG_LSB-1:`L2_INDEX_LSB];
            way_cmd.tag   <= req.addr[31:`L2_TAG_LSB];
            way_cmd.word  <= req.addr[`L2_INDEX_LSB-1:`L2_WORD_LSB];
            way_cmd.wdata <= {req.wdata, req.wdata};
            beat_cnt      <= '0;
            state         <= l2_pkg::lookup;
          end
        end

        l2_pkg::lookup:
        begin
          if (is_snoop)
          begin
            // Snoops change state only, LRU untouched
            if (merged.any_hit)
            begin
              way_cmd.set_state <= 1'b1;
              way_cmd.target    <= hit_sel;
              way_cmd.new_state <= (req_q.kind == l2_pkg::snoop_read) ?
                                   l2_pkg::shared : l2_pkg::invalid;
              write_back        <= (merged.hit_state == l2_pkg::modified);
              wb_addr           <= req_line;
            end
            state <= l2_pkg::respond;
          end
          else if (merged.any_hit)
          begin
            way_cmd.touch     <= 1'b1;
            way_cmd.touch_way <= merged.hit_way;
            way_cmd.touch_age <= merged.hit_age;
            way_cmd.target    <= hit_sel;
            if (is_write)
            begin
              way_cmd.write_word <= 1'b1;
              way_cmd.set_state  <= 1'b1;
              way_cmd.new_state  <= l2_pkg::modified;
            end
            else
              rdata <= merged.rword;
            state <= l2_pkg::respond;
          end
          else
          begin
            // Miss, start the fill into the victim
            victim_q     <= merged.victim_way;
            victim_age_q <= merged.victim_age;
            mem_req      <= 1'b1;
            mem_addr     <= req_line;
            if (merged.victim_state == l2_pkg::modified)
            begin
              write_back <= 1'b1;
              wb_addr    <= {merged.victim_tag, req_index, {`L2_INDEX_LSB{1'b0}}};
            end
            state <= l2_pkg::fill_wait;
          end
        end

        l2_pkg::fill_wait:
        begin
          if (mem_beat)
          begin
            way_cmd.fill_beat <= 1'b1;
            way_cmd.beat_num  <= beat_cnt;
            way_cmd.wdata     <= mem_data;
            way_cmd.target    <= victim_sel;
            beat_cnt          <= beat_cnt + 1'b1;
            // Catch the requested word as its beat goes by
            if (!is_write && (beat_cnt == req_word[sel_bits-1:lane_bits]))
              rdata <= mem_data[req_word[lane_bits-1:0]*word_bits +: word_bits];
            if (beat_cnt == beat_bits'(`L2_BEATS - 1))
            begin
              if (is_write)
                state <= l2_pkg::write_word;
              else
              begin
                // Last beat also installs the line
                way_cmd.set_state <= 1'b1;
                way_cmd.new_state <= l2_pkg::exclusive;
                way_cmd.touch     <= 1'b1;
                way_cmd.touch_way <= victim_q;
                way_cmd.touch_age <= victim_age_q;
                state             <= l2_pkg::respond;
              end
            end
          end
        end

        l2_pkg::write_word:
        begin
          // Merge the store into the freshly filled line
          way_cmd.write_word <= 1'b1;
          way_cmd.wdata      <= {req_q.wdata, req_q.wdata};
          way_cmd.set_state  <= 1'b1;
          way_cmd.new_state  <= l2_pkg::modified;
          way_cmd.touch      <= 1'b1;
          way_cmd.touch_way  <= victim_q;
          way_cmd.touch_age  <= victim_age_q;
          way_cmd.target     <= victim_sel;
          state              <= l2_pkg::respond;
        end

        l2_pkg::respond:
          state <= l2_pkg::idle;

        default:
          state <= l2_pkg::idle;
      endcase
    end
  end

endmodule

// File: hdl/l2_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache shared types
// Vector widths, MESI and FSM
// enums, bus structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "l2_settings.svh"

package l2_pkg;

  // Address and data widths
  typedef logic [31:0]                              addr_t;
  typedef logic [31-`L2_TAG_LSB:0]                  tag_t;
  typedef logic [`L2_TAG_LSB-`L2_INDEX_LSB-1:0]     index_t;
  typedef logic [`L2_INDEX_LSB-`L2_WORD_LSB-1:0]    word_sel_t;
  typedef logic [31:0]                              word_t;
  // Lower word travels in the low half
  typedef logic [63:0]                              beat_t;

  // Replacement bookkeeping, age 3 is most recent
  typedef logic [$clog2(`L2_WAYS)-1:0]              age_t;
  typedef logic [$clog2(`L2_WAYS)-1:0]              way_id_t;
  typedef logic [`L2_WAYS-1:0]                      way_vec_t;

  typedef enum logic [1:0] {invalid, exclusive, shared, modified} mesi_e;

  typedef enum logic [1:0] {cpu_read, cpu_write, snoop_read, snoop_write} req_kind_e;

  typedef enum logic [2:0] {idle, lookup, fill_wait, write_word, respond} ctrl_state_e;

  // Processor or snoop request
  typedef struct packed {
    req_kind_e kind;
    addr_t     addr;
    word_t     wdata;
  } cpu_req_t;

  // Broadcast to all ways
  typedef struct packed {
    index_t                        index;
    tag_t                          tag;
    word_sel_t                     word;
    // Full beat on fill, low word on a word write
    beat_t                         wdata;
    logic                          fill_beat;
    logic [$clog2(`L2_BEATS)-1:0]  beat_num;
    logic                          write_word;
    logic                          set_state;
    mesi_e                         new_state;
    logic                          touch;
    way_id_t                       touch_way;
    age_t                          touch_age;
    way_vec_t                      target;
  } way_cmd_t;

  // Per way lookup result
  typedef struct packed {
    logic   hit;
    mesi_e  state;
    age_t   age;
    tag_t   tag;
    word_t  rword;
  } way_status_t;

  // Merged result back to the controller
  typedef struct packed {
    logic    any_hit;
    way_id_t hit_way;
    mesi_e   hit_state;
    age_t    hit_age;
    way_id_t victim_way;
    mesi_e   victim_state;
    tag_t    victim_tag;
    age_t    victim_age;
    word_t   rword;
  } merge_result_t;

endpackage

// File: include/l2_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache geometry
// Way count, set count, line size
// and address field positions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef L2_SETTINGS_SVH
`define L2_SETTINGS_SVH

// Associativity and set count
`define L2_WAYS        4
`define L2_SETS        4

// Words per line and memory beats per fill
`define L2_LINE_WORDS  4
`define L2_BEATS       2

// Byte address layout
// tag | index | word | byte
`define L2_WORD_LSB    2
`define L2_INDEX_LSB   4
`define L2_TAG_LSB     6

`endif
